/* logic/data_memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defs.svh"

module data_memory_stage
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_valid,
    input  rv32i_pkg::rv32i_control_word ctrl,
    input  wire logic [`XLEN-1:0]      alu_out,
    input  wire logic [`XLEN-1:0]      rs2_data,
    input  wire logic [`XLEN-1:0]      pc_plus4,
    input  wire logic [`XLEN-1:0]      br_en,
    mem_wb_if.stage_out                wb
);
    import rv32i_pkg::*;

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic [3:0]        byte_en;
    logic [`XLEN-1:0]  store_data;
    logic [ADDR_W-1:0] word_addr;
    logic              do_write;
    logic              do_read;

    logic [`XLEN-1:0]  dmem [`DMEM_WORDS];

    assign word_addr = alu_out[ADDR_W+1:2];
    assign do_write  = in_valid && ctrl.mem_write;
    assign do_read   = in_valid && ctrl.mem_read;

    // lanes touched by the access.
    always_comb
    begin
        case (ctrl.store_width)
            st_sb:   byte_en = 4'b0001 << alu_out[1:0];
            st_sh:   byte_en = 4'b0011 << alu_out[1:0];    // offset 3 keeps top lane only.
            st_sw:   byte_en = 4'b1111;
            default: byte_en = 4'b1111;
        endcase
    end

    // rs2 low bytes moved up to the addressed lane.
    assign store_data = rs2_data << {alu_out[1:0], 3'b000};

    // byte-enabled ram, read returns the word before this edge's write.
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byte_en[i])
                    dmem[word_addr][8*i +: 8] <= store_data[8*i +: 8];
            end
        end
        if (do_read)
            wb.r_data <= dmem[word_addr];
    end

    // mem/wb control.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wb.valid <= 1'b0;
        else
            wb.valid <= in_valid;
    end

    // mem/wb payload.
    always_ff @(posedge clk)
    begin
        wb.ctrl            <= ctrl;
        wb.mem_byte_enable <= byte_en;
        wb.alu             <= alu_out;
        wb.br_en           <= br_en;
        wb.pc_plus4        <= pc_plus4;
    end

endmodule

`default_nettype wire

/* logic/mem_wb_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defs.svh"

interface mem_wb_if;
    import rv32i_pkg::*;

    logic              valid;
    rv32i_control_word ctrl;
    logic [3:0]        mem_byte_enable;
    logic [`XLEN-1:0]  r_data;           // ram read word.
    logic [`XLEN-1:0]  alu;
    logic [`XLEN-1:0]  br_en;
    logic [`XLEN-1:0]  pc_plus4;

    modport stage_out (
        output valid, ctrl, mem_byte_enable, r_data, alu, br_en, pc_plus4
    );

    modport stage_in (
        input valid, ctrl, mem_byte_enable, r_data, alu, br_en, pc_plus4
    );

endinterface

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defs.svh"

module regfile
(
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             load,
    input  wire logic [4:0]       dest,
    input  wire logic [`XLEN-1:0] in,
    input  wire logic [4:0]       src_a,
    input  wire logic [4:0]       src_b,
    output logic [`XLEN-1:0]      reg_a,
    output logic [`XLEN-1:0]      reg_b
);

    // x0 has no storage.
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        if (load && addr == dest)
            return in;                   // write-through.
        return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (load && dest != 5'd0)
            regs[dest] <= in;
    end

    always_comb
    begin
        reg_a = read_port(src_a);
        reg_b = read_port(src_b);
    end

endmodule

`default_nettype wire

/* logic/rv32i_backend.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defs.svh"

module rv32i_backend
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    input  wire logic                   load_regfile,
    input  wire logic                   mem_read,
    input  wire logic                   mem_write,
    input  wire logic [4:0]             rd,
    input  rv32i_pkg::regfilemux_sel_t  regfilemux_sel,
    input  rv32i_pkg::store_width_t     store_width,
    input  wire logic [`XLEN-1:0]       u_imm,
    input  wire logic [`XLEN-1:0]       alu_out,
    input  wire logic [`XLEN-1:0]       rs2_data,
    input  wire logic [`XLEN-1:0]       pc_plus4,
    input  wire logic [`XLEN-1:0]       br_en,
    input  wire logic [4:0]             rs1_addr,
    input  wire logic [4:0]             rs2_addr,
    output logic [`XLEN-1:0]            rs1_data,
    output logic [`XLEN-1:0]            rs2_data_out,
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd,
    output logic [`XLEN-1:0]            wb_data
);
    import rv32i_pkg::*;

    rv32i_control_word ctrl;
    logic              rf_load;
    logic [4:0]        rf_dest;
    logic [`XLEN-1:0]  rf_data;

    mem_wb_if mem_wb ();

    assign ctrl = '{
        load_regfile:   load_regfile,
        rd:             rd,
        regfilemux_sel: regfilemux_sel,
        u_imm:          u_imm,
        mem_read:       mem_read,
        mem_write:      mem_write,
        store_width:    store_width
    };

    data_memory_stage u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .ctrl     (ctrl),
        .alu_out  (alu_out),
        .rs2_data (rs2_data),
        .pc_plus4 (pc_plus4),
        .br_en    (br_en),
        .wb       (mem_wb)
    );

    write_back u_wb (
        .wb           (mem_wb),
        .load_regfile (rf_load),
        .rd           (rf_dest),
        .rd_in        (rf_data)
    );

    regfile u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (rf_load),
        .dest  (rf_dest),
        .in    (rf_data),
        .src_a (rs1_addr),
        .src_b (rs2_addr),
        .reg_a (rs1_data),
        .reg_b (rs2_data_out)
    );

    // forwarding path for execute.
    assign wb_valid = mem_wb.valid;
    assign wb_rd    = rf_dest;
    assign wb_data  = rf_data;

endmodule

`default_nettype wire

/* logic/rv32i_defs.svh */
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// data word width.
`define XLEN 32

// architectural registers, x0 included.
`define REG_COUNT 32

// data ram depth in words, indexed by alu_out[9:2].
`define DMEM_WORDS 256

`endif

/* logic/rv32i_pkg.sv */
`default_nettype none

`include "rv32i_defs.svh"

package rv32i_pkg;

    typedef enum logic [3:0] {
        rf_alu_out  = 4'd0,
        rf_br_en    = 4'd1,
        rf_u_imm    = 4'd2,
        rf_lw       = 4'd3,
        rf_pc_plus4 = 4'd4,
        rf_lb       = 4'd5,
        rf_lbu      = 4'd6,
        rf_lh       = 4'd7,
        rf_lhu      = 4'd8
    } regfilemux_sel_t;

    // width of the data access, loads included.
    typedef enum logic [1:0] {
        st_sb = 2'd0,
        st_sh = 2'd1,
        st_sw = 2'd2
    } store_width_t;

    typedef struct packed {
        logic             load_regfile;
        logic [4:0]       rd;
        regfilemux_sel_t  regfilemux_sel;
        logic [`XLEN-1:0] u_imm;
        logic             mem_read;
        logic             mem_write;
        store_width_t     store_width;
    } rv32i_control_word;

endpackage

`default_nettype wire

/* logic/write_back.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defs.svh"

module write_back
(
    mem_wb_if.stage_in             wb,
    output logic                   load_regfile,
    output logic [4:0]             rd,
    output logic [`XLEN-1:0]       rd_in
);
    import rv32i_pkg::*;

    logic [7:0]       load_byte;
    logic [15:0]      load_half;
    logic             half_top;          // half access at offset 3.
    logic [`XLEN-1:0] regfilemux_out;

    assign load_regfile = wb.valid & wb.ctrl.load_regfile;
    assign rd           = wb.ctrl.rd;
    assign rd_in        = regfilemux_out;

    // byte lane pick.
    always_comb
    begin
        case (wb.mem_byte_enable)
            4'b0010: load_byte = wb.r_data[15:8];
            4'b0100: load_byte = wb.r_data[23:16];
            4'b1000: load_byte = wb.r_data[31:24];
            default: load_byte = wb.r_data[7:0];
        endcase
    end

    // half lane pick.
    always_comb
    begin
        half_top = 1'b0;
        case (wb.mem_byte_enable)
            4'b0110: load_half = wb.r_data[23:8];
            4'b1100: load_half = wb.r_data[31:16];
            4'b1000:
            begin
                load_half = {8'h00, wb.r_data[31:24]};
                half_top  = 1'b1;
            end
            default: load_half = wb.r_data[15:0];
        endcase
    end

    always_comb
    begin
        case (wb.ctrl.regfilemux_sel)
            rf_alu_out:  regfilemux_out = wb.alu;
            rf_br_en:    regfilemux_out = wb.br_en;
            rf_u_imm:    regfilemux_out = wb.ctrl.u_imm;
            rf_lw:       regfilemux_out = wb.r_data;
            rf_pc_plus4: regfilemux_out = wb.pc_plus4;
            rf_lb:       regfilemux_out = {{24{load_byte[7]}}, load_byte};
            rf_lbu:      regfilemux_out = {24'h000000, load_byte};
            rf_lh:
            begin
                if (half_top)
                    regfilemux_out = {{24{load_half[7]}}, load_half[7:0]};
                else
                    regfilemux_out = {{16{load_half[15]}}, load_half};
            end
            rf_lhu:      regfilemux_out = {16'h0000, load_half};   // top lane already zero-padded.
            default:     regfilemux_out = wb.alu;
        endcase
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the backend testbench with verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module backend_tb -o backend_sim
if ./obj_dir/backend_sim | tee /dev/stderr | grep -F "Test completed successfully" > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb.f */
+incdir+logic
logic/rv32i_pkg.sv
logic/mem_wb_if.sv
logic/data_memory_stage.sv
logic/write_back.sv
logic/regfile.sv
logic/rv32i_backend.sv
verification/backend_assert.sv
verification/backend_tb.sv

/* verification/backend_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module backend_assert
(
    input wire logic                clk,
    input wire logic                rst_n,
    input rv32i_pkg::store_width_t  width,
    input wire logic [3:0]          byte_en,
    input wire logic                valid,
    input wire logic [4:0]          src_a,
    input wire logic [31:0]         reg_a
);
    import rv32i_pkg::*;

    // a byte access touches exactly one lane.
    assert property (@(posedge clk) disable iff (!rst_n) width == st_sb |-> $onehot(byte_en))
        else $error("byte access enable is not one-hot");

    assert property (@(posedge clk) !rst_n |=> !valid)
        else $error("stage valid set in the cycle after reset");

    // x0 never holds a written value.
    assert property (@(posedge clk) disable iff (!rst_n) src_a == 5'd0 |-> reg_a == 32'd0)
        else $error("x0 read back nonzero");

endmodule

bind data_memory_stage backend_assert mem_checks (
    .clk (clk), .rst_n (rst_n), .width (ctrl.store_width), .byte_en (byte_en),
    .valid (wb.valid), .src_a (5'd1), .reg_a (32'd0)
);

bind regfile backend_assert rf_checks (
    .clk (clk), .rst_n (rst_n), .width (rv32i_pkg::st_sw), .byte_en (4'b1111),
    .valid (load), .src_a (src_a), .reg_a (reg_a)
);

`default_nettype wire

/* verification/backend_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defs.svh"

module backend_tb;
    import rv32i_pkg::*;

    localparam int CLK_HALF    = 4;
    localparam int MAX_LINES   = 64;
    localparam int RAND_COUNT  = 40;
    localparam int WATCHDOG_NS = (MAX_LINES + RAND_COUNT) * 4 * 8 + 2000;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             load_regfile;
    logic             mem_read;
    logic             mem_write;
    logic [4:0]       rd;
    regfilemux_sel_t  regfilemux_sel;
    store_width_t     store_width;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] br_en;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data_out;
    logic             wb_valid;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;

    // current data file line.
    logic [31:0] f_valid, f_load, f_mrd, f_mwr, f_rd, f_sel, f_width;
    logic [31:0] f_uimm, f_alu, f_rs2, f_pc, f_br, f_chk, f_exp;

    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [`XLEN-1:0] model_mem  [`DMEM_WORDS];

    rv32i_backend dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .load_regfile   (load_regfile),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .rd             (rd),
        .regfilemux_sel (regfilemux_sel),
        .store_width    (store_width),
        .u_imm          (u_imm),
        .alu_out        (alu_out),
        .rs2_data       (rs2_data),
        .pc_plus4       (pc_plus4),
        .br_en          (br_en),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data_out   (rs2_data_out),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    always #CLK_HALF clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED: %s actual %h expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [31:0] model_result(input regfilemux_sel_t sel,
                                                 input logic [31:0] alu, input logic [31:0] uimm,
                                                 input logic [31:0] pc, input logic [31:0] br,
                                                 input logic [31:0] word);
        logic [31:0] lane;
        logic        single;
        lane   = word >> {alu[1:0], 3'b000};
        single = (alu[1:0] == 2'd3);    // half at offset 3 sees one byte.
        case (sel)
            rf_alu_out:  return alu;
            rf_br_en:    return br;
            rf_u_imm:    return uimm;
            rf_pc_plus4: return pc;
            rf_lw:       return word;
            rf_lb:       return {{24{lane[7]}}, lane[7:0]};
            rf_lbu:      return {24'h000000, lane[7:0]};
            rf_lh:       return single ? {{24{lane[7]}}, lane[7:0]} : {{16{lane[15]}}, lane[15:0]};
            default:     return {16'h0000, lane[15:0]};
        endcase
    endfunction

    function automatic logic [31:0] merged_word(input store_width_t width, input logic [1:0] off,
                                                input logic [31:0] old, input logic [31:0] src);
        logic [31:0] result;
        int          first;
        int          count;
        result = old;
        first  = (width == st_sw) ? 0 : int'(off);
        count  = (width == st_sw) ? 4 : (width == st_sh) ? 2 : 1;
        for (int b = first; b < first + count && b < 4; b++)
            result[8*b +: 8] = src[8*(b-first) +: 8];
        return result;
    endfunction

    task automatic apply_line();
        logic [31:0] expected;
        logic [31:0] old_word;
        old_word = model_mem[f_alu[9:2]];
        @(posedge clk);
        #1;
        in_valid       = f_valid[0];
        load_regfile   = f_load[0];
        mem_read       = f_mrd[0];
        mem_write      = f_mwr[0];
        rd             = f_rd[4:0];
        regfilemux_sel = regfilemux_sel_t'(f_sel[3:0]);
        store_width    = store_width_t'(f_width[1:0]);
        u_imm          = f_uimm;
        alu_out        = f_alu;
        rs2_data       = f_rs2;
        pc_plus4       = f_pc;
        br_en          = f_br;
        expected = model_result(regfilemux_sel, f_alu, f_uimm, f_pc, f_br, old_word);
        @(posedge clk);
        #1;
        in_valid  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        rs2_addr  = f_rd[4:0];
        #2;
        check_value("wb_valid", 32'(wb_valid), {31'h0, f_valid[0]});
        if (f_valid[0])
        begin
            check_value("wb_rd", 32'(wb_rd), {27'h0, f_rd[4:0]});
            check_value("wb_data", wb_data, expected);
            if (f_load[0])
                check_value("rs2_data_out bypass", rs2_data_out,
                            (f_rd[4:0] == 5'd0) ? 32'd0 : expected);
        end
        if (f_valid[0] && f_mwr[0])
            model_mem[f_alu[9:2]] = merged_word(store_width_t'(f_width[1:0]), f_alu[1:0],
                                                old_word, f_rs2);
        if (f_valid[0] && f_load[0] && f_rd[4:0] != 5'd0)
            model_regs[f_rd[4:0]] = expected;
        repeat (2) @(posedge clk);
        #1;
        rs1_addr = f_chk[4:0];
        #2;
        check_value("rs1_data", rs1_data, f_exp);
        check_value("rs1_data model", rs1_data, model_regs[f_chk[4:0]]);
    endtask

    task automatic run_data_file();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verification/backend_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file");
            $display("Test failed");
            $fatal(1, "no stimulus");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f_valid, f_load, f_mrd, f_mwr, f_rd, f_sel, f_width,
                                f_uimm, f_alu, f_rs2, f_pc, f_br, f_chk, f_exp);
                    if (n != 14)
                    begin
                        $display("malformed line in the test data file: %s", line);
                        $display("Test failed");
                        $fatal(1, "bad stimulus");
                    end
                    else
                        apply_line();
                end
            end
            $fclose(fd);
        end
    endtask

    // back-to-back alu style traffic, one new instruction per cycle.
    task automatic run_random_stream();
        logic [31:0] r;
        logic [31:0] next_data;
        logic [31:0] pend_data;
        logic [4:0]  pend_rd;
        logic        pend_load;
        pend_data = '0;
        pend_rd   = '0;
        pend_load = 1'b0;
        for (int i = 0; i <= RAND_COUNT; i++)
        begin
            @(posedge clk);
            #1;
            rs2_addr  = pend_rd;
            next_data = '0;
            if (i < RAND_COUNT)
            begin
                r            = $urandom;
                in_valid     = 1'b1;
                load_regfile = r[7] | r[8];
                mem_read     = 1'b0;
                mem_write    = 1'b0;
                store_width  = st_sw;
                rd           = r[4:0];
                alu_out      = $urandom;
                u_imm        = $urandom & 32'hfffff000;
                pc_plus4     = $urandom & 32'hfffffffc;
                br_en        = {31'h0, r[9]};
                case (r[6:5])
                    2'd0: regfilemux_sel = rf_alu_out;
                    2'd1: regfilemux_sel = rf_br_en;
                    2'd2: regfilemux_sel = rf_u_imm;
                    default: regfilemux_sel = rf_pc_plus4;
                endcase
                next_data = model_result(regfilemux_sel, alu_out, u_imm, pc_plus4, br_en, '0);
            end
            else
                in_valid = 1'b0;
            #2;
            if (i > 0)
            begin
                check_value("wb_valid", 32'(wb_valid), 32'd1);
                check_value("wb_rd", 32'(wb_rd), {27'h0, pend_rd});
                check_value("wb_data", wb_data, pend_data);
                if (pend_load && pend_rd != 5'd0)
                begin
                    check_value("rs2_data_out bypass", rs2_data_out, pend_data);
                    model_regs[pend_rd] = pend_data;
                end
            end
            pend_data = next_data;
            pend_rd   = rd;
            pend_load = load_regfile;
        end
    endtask

    initial
    begin
        void'($urandom(32'h9dc3));
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        load_regfile   = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        rd             = '0;
        regfilemux_sel = rf_alu_out;
        store_width    = st_sw;
        u_imm          = '0;
        alu_out        = '0;
        rs2_data       = '0;
        pc_plus4       = '0;
        br_en          = '0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++)
            model_mem[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("wb_valid after reset", 32'(wb_valid), 32'd0);
        for (int i = 0; i < `REG_COUNT; i++)
        begin
            rs1_addr = 5'(i);
            rs2_addr = 5'(i);
            #1;
            check_value("rs1_data after reset", rs1_data, 32'd0);
            check_value("rs2_data_out after reset", rs2_data_out, 32'd0);
        end
        run_data_file();
        run_random_stream();
        @(posedge clk);
        #1;
        for (int i = 0; i < `REG_COUNT; i++)
        begin
            rs1_addr = 5'(i);
            #1;
            check_value("rs1_data final", rs1_data, model_regs[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/backend_testdata.txt */
# valid load_regfile mem_read mem_write rd sel width u_imm alu_out rs2_data pc_plus4 br_en chk_reg expected
# all hex; sel 0 alu 1 br 2 u 3 lw 4 pc 5 lb 6 lbu 7 lh 8 lhu; width 0 byte 1 half 2 word
1 1 0 0 01 0 2 00000000 12345678 00000000 00000004 00000000 01 12345678
1 1 0 0 02 1 2 00000000 00000000 00000000 00000008 00000001 02 00000001
1 1 0 0 03 2 2 abcde000 00000000 00000000 0000000c 00000000 03 abcde000
1 1 0 0 04 4 2 00000000 00000000 00000000 00000010 00000000 04 00000010
1 0 0 1 00 0 2 00000000 00000040 11223344 00000014 00000000 05 00000000
1 1 1 0 05 3 2 00000000 00000040 00000000 00000018 00000000 05 11223344
1 0 0 1 00 0 1 00000000 00000042 0000aabb 0000001c 00000000 05 11223344
1 0 0 1 00 0 0 00000000 00000041 000000cc 00000020 00000000 05 11223344
1 1 1 0 06 3 2 00000000 00000040 00000000 00000024 00000000 06 aabbcc44
0 0 0 1 00 0 2 00000000 00000040 ffffffff 00000028 00000000 06 aabbcc44
1 1 0 0 00 0 2 00000000 deadbeef 00000000 0000002c 00000000 00 00000000
1 0 0 0 01 0 2 00000000 0badf00d 00000000 00000030 00000000 01 12345678
0 1 0 0 02 0 2 00000000 0badf00d 00000000 00000034 00000000 02 00000001
1 1 1 0 08 5 0 00000000 00000040 00000000 00000000 00000000 08 00000044
1 1 1 0 09 5 0 00000000 00000041 00000000 00000000 00000000 09 ffffffcc
1 1 1 0 0a 5 0 00000000 00000042 00000000 00000000 00000000 0a ffffffbb
1 1 1 0 0b 5 0 00000000 00000043 00000000 00000000 00000000 0b ffffffaa
1 1 1 0 0c 6 0 00000000 00000040 00000000 00000000 00000000 0c 00000044
1 1 1 0 0d 6 0 00000000 00000041 00000000 00000000 00000000 0d 000000cc
1 1 1 0 0e 6 0 00000000 00000042 00000000 00000000 00000000 0e 000000bb
1 1 1 0 0f 6 0 00000000 00000043 00000000 00000000 00000000 0f 000000aa
1 1 1 0 10 7 1 00000000 00000040 00000000 00000000 00000000 10 ffffcc44
1 1 1 0 11 7 1 00000000 00000041 00000000 00000000 00000000 11 ffffbbcc
1 1 1 0 12 7 1 00000000 00000042 00000000 00000000 00000000 12 ffffaabb
1 1 1 0 13 7 1 00000000 00000043 00000000 00000000 00000000 13 ffffffaa
1 1 1 0 14 8 1 00000000 00000040 00000000 00000000 00000000 14 0000cc44
1 1 1 0 15 8 1 00000000 00000041 00000000 00000000 00000000 15 0000bbcc
1 1 1 0 16 8 1 00000000 00000042 00000000 00000000 00000000 16 0000aabb
1 1 1 0 17 8 1 00000000 00000043 00000000 00000000 00000000 17 000000aa
